//--- lease_vectors.hex
// op(1) addr(4) data-or-line(8) done-delay(1) exp-addr(1, f any) flags(1) exp-rdata(8)
// op 1 axi write, 2 axi read, 3 hit, 4 miss; flags swap,expired,expired_multi,default
100800000003c00000000000
20080000000000000000003c
100800000000000000000000
100000000004000000000000
100200000000500000000000
100600000010000000000000
100040000004100000000000
100240000000900000000000
100440000000200000000000
100640000000000000000000
40100000000001f100000000
400400000000020e00000000
30040000000001f000000000
400400000000021e00000000
30040000000011f000000000
30200000000011f100000000
30041000000021f000000000
30040000000011f000000000
30040000000001f000000000
400400000000022e00000000
30040000000021f000000000
100800000004000000000000
30300000000001f100000000
30300000000011f100000000
30300000000021f100000000
30300000000031f100000000
30300000000041f100000000
30300000000051f100000000
30300000000061f100000000
403000000000027d00000000
30300000000071f000000000
40040000000002f800000000

//--- sim.f
lease_pkg.sv
lease_table_if.sv
lease_cfg_axil.sv
lease_lookup_table.sv
lease_prob_select.sv
lease_replace_ctrl.sv
lease_cache_top.sv
lease_checker.sv
lease_tb.sv

//--- Bender.yml
package:
  name: lease_cache

sources:
  - lease_pkg.sv
  - lease_table_if.sv
  - lease_cfg_axil.sv
  - lease_lookup_table.sv
  - lease_prob_select.sv
  - lease_replace_ctrl.sv
  - lease_cache_top.sv
  - target: test
    files:
      - lease_checker.sv
      - lease_tb.sv

//--- lease_tb.sv
/* lease cache testbench
   reads the vector file, drives axi config writes and cache strobes, ends on timeout */
`timescale 1ns/1ps

module lease_tb;

	localparam int NUM_VEC        = 32;
	localparam int RESET_CYCLES   = 10;
	localparam int TIMEOUT_CYCLES = NUM_VEC * 20 + RESET_CYCLES;

	// vector opcodes
	localparam logic [3:0] OP_AXI_WR = 4'h1;
	localparam logic [3:0] OP_AXI_RD = 4'h2;
	localparam logic [3:0] OP_HIT    = 4'h3;
	localparam logic [3:0] OP_MISS   = 4'h4;

	logic clock_i, resetn_i;
	logic [lease_pkg::AXI_AW-1:0] s_awaddr_i, s_araddr_i;
	logic [lease_pkg::AXI_DW-1:0] s_wdata_i, s_rdata_o;
	logic s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o;
	logic s_bvalid_o, s_bready_i, s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
	logic [1:0] s_bresp_o, s_rresp_o;
	logic hit_i, miss_i;
	logic [lease_pkg::REF_AW-1:0]  ref_addr_i;
	logic [lease_pkg::LINE_AW-1:0] line_i, addr_o;
	logic done_o, swap_o, expired_o, expired_multi_o, default_o;

	logic [95:0] vectors [NUM_VEC];   // op, addr, data, then expected fields
	logic [95:0] vec;
	logic        start, step_done;
	int          fail_cnt, cycles;

	lease_cache_top i_lease_cache_top (
		.clock_i, .resetn_i,
		.s_awaddr_i, .s_awvalid_i, .s_awready_o, .s_wdata_i, .s_wvalid_i, .s_wready_o,
		.s_bresp_o, .s_bvalid_o, .s_bready_i, .s_araddr_i, .s_arvalid_i, .s_arready_o,
		.s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
		.hit_i, .miss_i, .ref_addr_i, .line_i,
		.done_o, .addr_o, .swap_o, .expired_o, .expired_multi_o, .default_o
	);

	lease_checker #(
		.OP_AXI_WR (OP_AXI_WR), .OP_AXI_RD (OP_AXI_RD), .OP_HIT (OP_HIT), .OP_MISS (OP_MISS),
		.NUM_TESTS (NUM_VEC)
	) i_lease_checker (
		.clock_i, .start_i (start), .vec_i (vec),
		.done_i (done_o), .addr_i (addr_o), .swap_i (swap_o), .expired_i (expired_o),
		.expired_multi_i (expired_multi_o), .default_i (default_o),
		.bvalid_i (s_bvalid_o), .bresp_i (s_bresp_o),
		.rvalid_i (s_rvalid_o), .rresp_i (s_rresp_o), .rdata_i (s_rdata_o),
		.step_done_o (step_done), .fail_cnt_o (fail_cnt)
	);

	initial clock_i = 1'b0;
	always #5 clock_i = ~clock_i;   // 10 ns period

	// --------------------------------------------------
	// run limit
	always @(posedge clock_i) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// drives one vector and waits for the checker to close it
	task automatic run_vector(input logic [95:0] v);
		logic [3:0] op;
		op    = v[95:92];
		vec   <= v;
		start <= 1'b1;
		if (op == OP_AXI_WR) begin
			s_awaddr_i  <= v[83:76];
			s_wdata_i   <= v[75:44];
			s_awvalid_i <= 1'b1;
			s_wvalid_i  <= 1'b1;
		end else if (op == OP_AXI_RD) begin
			s_araddr_i  <= v[83:76];
			s_arvalid_i <= 1'b1;
		end else begin
			hit_i      <= (op == OP_HIT);
			miss_i     <= (op == OP_MISS);
			ref_addr_i <= v[91:76];
			line_i     <= v[46:44];
		end
		@(posedge clock_i);
		start  <= 1'b0;
		hit_i  <= 1'b0;   // single cycle strobes
		miss_i <= 1'b0;
		while ((s_awvalid_i && !s_awready_o) || (s_wvalid_i && !s_wready_o) ||
			(s_arvalid_i && !s_arready_o))
			@(posedge clock_i);
		s_awvalid_i <= 1'b0;
		s_wvalid_i  <= 1'b0;
		s_arvalid_i <= 1'b0;
		while (!step_done)
			@(posedge clock_i);
	endtask

	// --------------------------------------------------
	initial begin
		cycles = 0;
		start <= 1'b0;
		vec <= '0;
		resetn_i <= 1'b0;
		s_awaddr_i <= '0;
		s_awvalid_i <= 1'b0;
		s_wdata_i <= '0;
		s_wvalid_i <= 1'b0;
		s_bready_i <= 1'b1;   // responses taken at once
		s_araddr_i <= '0;
		s_arvalid_i <= 1'b0;
		s_rready_i <= 1'b1;
		hit_i <= 1'b0;
		miss_i <= 1'b0;
		ref_addr_i <= '0;
		line_i <= '0;
		$readmemh("lease_vectors.hex", vectors);
		repeat (RESET_CYCLES) @(posedge clock_i);
		resetn_i <= 1'b1;
		@(posedge clock_i);
		for (int i = 0; i < NUM_VEC; i++)
			run_vector(vectors[i]);
		if (fail_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- lease_checker.sv
/* lease checker
   watches the DUT ports during each test step and compares them with the expected vector fields */
`timescale 1ns/1ps

module lease_checker #(
	parameter logic [3:0] OP_AXI_WR = 4'h0,
	parameter logic [3:0] OP_AXI_RD = 4'h0,
	parameter logic [3:0] OP_HIT    = 4'h0,
	parameter logic [3:0] OP_MISS   = 4'h0,
	parameter int         NUM_TESTS = 1
) (
	input  logic        clock_i,
	input  logic        start_i,            // stimulus of a new step enters the DUT
	input  logic [95:0] vec_i,
	input  logic        done_i,
	input  logic [2:0]  addr_i,
	input  logic        swap_i,
	input  logic        expired_i,
	input  logic        expired_multi_i,
	input  logic        default_i,
	input  logic        bvalid_i,
	input  logic [1:0]  bresp_i,
	input  logic        rvalid_i,
	input  logic [1:0]  rresp_i,
	input  logic [31:0] rdata_i,
	output logic        step_done_o,
	output int          fail_cnt_o
);

	localparam int RESP_LIMIT = 8;   // cycles allowed for any response

	logic        busy, bad;
	logic [95:0] vec;
	logic [3:0]  op, exp_delay, exp_addr, exp_flags;
	logic [31:0] exp_rdata;
	int          cnt, test_no, pass_cnt, fail_cnt;

	// vector fields
	assign op        = vec[95:92];
	assign exp_delay = vec[43:40];
	assign exp_addr  = vec[39:36];   // f means any line
	assign exp_flags = vec[35:32];   // swap, expired, expired_multi, default
	assign exp_rdata = vec[31:0];
	assign fail_cnt_o = fail_cnt;

	initial begin
		busy        = 1'b0;
		bad         = 1'b0;
		vec         = '0;
		cnt         = 0;
		test_no     = 0;
		pass_cnt    = 0;
		fail_cnt    = 0;
		step_done_o = 1'b0;
	end

	function automatic string op_name(input logic [3:0] code);
		if (code == OP_AXI_WR)
			return "axi write";
		else if (code == OP_AXI_RD)
			return "axi read";
		else if (code == OP_HIT)
			return "hit";
		else if (code == OP_MISS)
			return "miss";
		else
			return "unknown op";
	endfunction

	function automatic string resp_name(input logic [3:0] code);
		if (code == OP_AXI_WR)
			return "write response (bvalid)";
		else if (code == OP_AXI_RD)
			return "read response (rvalid)";
		else
			return "done_o";
	endfunction

	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s expected 0x%0h actual 0x%0h in test %0d", name, exp, act, test_no);
			bad = 1'b1;
		end
	endtask

	task automatic close_test();
		if (bad) begin
			fail_cnt++;
			$display("test %0d %s failed", test_no, op_name(op));
		end else begin
			pass_cnt++;
			$display("test %0d %s ok", test_no, op_name(op));
		end
		test_no++;
		busy = 1'b0;
		step_done_o <= 1'b1;   // lets the stimulus side move on
		if (test_no == NUM_TESTS)
			$display("summary: %0d passed, %0d failed of %0d tests", pass_cnt, fail_cnt, NUM_TESTS);
	endtask

	// --------------------------------------------------
	// one step at a time, cnt counts edges after the strobe was sampled
	always @(posedge clock_i) begin
		step_done_o <= 1'b0;
		if (start_i) begin
			vec  = vec_i;
			busy = 1'b1;
			bad  = 1'b0;
			cnt  = 0;
		end else if (busy) begin
			cnt++;
			if (op == OP_AXI_WR && bvalid_i) begin
				compare("s_bresp_o", 32'h0, bresp_i);
				close_test();
			end else if (op == OP_AXI_RD && rvalid_i) begin
				compare("s_rresp_o", 32'h0, rresp_i);
				compare("s_rdata_o", exp_rdata, rdata_i);
				close_test();
			end else if (op == OP_HIT) begin
				// hits move default_o only, one cycle later
				compare("done_o", 32'h0, done_i);
				compare("default_o", exp_flags[0], default_i);
				close_test();
			end else if (op == OP_MISS && done_i) begin
				if (cnt != exp_delay) begin
					$display("test %0d: done_o came %0d cycles after the miss, expected %0d",
						test_no, cnt, exp_delay);
					bad = 1'b1;
				end
				compare("swap_o", exp_flags[3], swap_i);
				compare("expired_o", exp_flags[2], expired_i);
				compare("expired_multi_o", exp_flags[1], expired_multi_i);
				compare("default_o", exp_flags[0], default_i);
				if (exp_addr != 4'hf)
					compare("addr_o", exp_addr, addr_i);
				close_test();
			end else if (cnt >= RESP_LIMIT) begin
				$display("test %0d: no %s within %0d cycles", test_no, resp_name(op), RESP_LIMIT);
				bad = 1'b1;
				close_test();
			end
		end
	end

endmodule

//--- lease_cache_top.sv
/* lease cache replacement top
   axi4-lite config slave, lease table, lease selector and replacement controller */
`timescale 1ns/1ps

module lease_cache_top (
	input  logic                            clock_i,
	input  logic                            resetn_i,
	// axi4-lite config slave
	input  logic [lease_pkg::AXI_AW-1:0]    s_awaddr_i,
	input  logic                            s_awvalid_i,
	output logic                            s_awready_o,
	input  logic [lease_pkg::AXI_DW-1:0]    s_wdata_i,
	input  logic                            s_wvalid_i,
	output logic                            s_wready_o,
	output logic [1:0]                      s_bresp_o,
	output logic                            s_bvalid_o,
	input  logic                            s_bready_i,
	input  logic [lease_pkg::AXI_AW-1:0]    s_araddr_i,
	input  logic                            s_arvalid_i,
	output logic                            s_arready_o,
	output logic [lease_pkg::AXI_DW-1:0]    s_rdata_o,
	output logic [1:0]                      s_rresp_o,
	output logic                            s_rvalid_o,
	input  logic                            s_rready_i,
	// cache controller side
	input  logic                            hit_i,
	input  logic                            miss_i,
	input  logic [lease_pkg::REF_AW-1:0]    ref_addr_i,
	input  logic [lease_pkg::LINE_AW-1:0]   line_i,
	output logic                            done_o,
	output logic [lease_pkg::LINE_AW-1:0]   addr_o,
	output logic                            swap_o,
	output logic                            expired_o,
	output logic                            expired_multi_o,
	output logic                            default_o
);

	logic [lease_pkg::LEASE_W-1:0] default_lease, chosen_lease;
	logic step_en;

	lease_table_if tbl ();

	// --------------------------------------------------
	lease_cfg_axil i_lease_cfg_axil (
		.clock_i, .resetn_i,
		.s_awaddr_i, .s_awvalid_i, .s_awready_o,
		.s_wdata_i, .s_wvalid_i, .s_wready_o,
		.s_bresp_o, .s_bvalid_o, .s_bready_i,
		.s_araddr_i, .s_arvalid_i, .s_arready_o,
		.s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
		.tbl             (tbl),
		.default_lease_o (default_lease)
	);

	lease_lookup_table i_lease_lookup_table (
		.clock_i, .resetn_i,
		.tbl (tbl)
	);

	lease_prob_select i_lease_prob_select (
		.clock_i, .resetn_i,
		.step_en_i      (step_en),
		.tbl            (tbl),
		.chosen_lease_o (chosen_lease)
	);

	lease_replace_ctrl i_lease_replace_ctrl (
		.clock_i, .resetn_i,
		.hit_i, .miss_i, .ref_addr_i, .line_i,
		.default_lease_i (default_lease),
		.chosen_lease_i  (chosen_lease),
		.step_en_o       (step_en),
		.tbl             (tbl),
		.done_o, .addr_o, .swap_o,
		.expired_o, .expired_multi_o, .default_o
	);

endmodule

//--- lease_replace_ctrl.sv
/* lease replacement controller
   per line lease countdown, renewal on hit and miss, victim line selection */
`timescale 1ns/1ps

module lease_replace_ctrl (
	input  logic                           clock_i,
	input  logic                           resetn_i,
	input  logic                           hit_i,
	input  logic                           miss_i,
	input  logic [lease_pkg::REF_AW-1:0]   ref_addr_i,
	input  logic [lease_pkg::LINE_AW-1:0]  line_i,
	input  logic [lease_pkg::LEASE_W-1:0]  default_lease_i,
	input  logic [lease_pkg::LEASE_W-1:0]  chosen_lease_i,
	output logic                           step_en_o,
	lease_table_if.ctrl                    tbl,
	output logic                           done_o,
	output logic [lease_pkg::LINE_AW-1:0]  addr_o,
	output logic                           swap_o,
	output logic                           expired_o,
	output logic                           expired_multi_o,
	output logic                           default_o
);

	lease_pkg::ctrl_state_e state_q;
	logic [lease_pkg::LEASE_W-1:0] lease_q [lease_pkg::CACHE_LINES];   // one per line
	logic [lease_pkg::LEASE_W-1:0] saved_lease_q, sel_lease;
	logic miss_followup_q, miss_default_q;
	logic [lease_pkg::CACHE_LINES-1:0] zero_lines;
	logic [lease_pkg::LINE_AW-1:0] low_idx, high_idx;
	logic [8:0] lfsr_q;   // backup victim source

	assign tbl.search_addr = ref_addr_i;
	assign step_en_o = (state_q == lease_pkg::ST_IDLE) & (hit_i | miss_i);
	assign sel_lease = tbl.llt_hit ? chosen_lease_i : default_lease_i;   // default on table miss

	// --------------------------------------------------
	// expired lines and both priority encoders
	always_comb begin
		low_idx  = '0;
		high_idx = '0;
		for (int i = 0; i < lease_pkg::CACHE_LINES; i++)
			zero_lines[i] = (lease_q[i] == '0);
		for (int i = lease_pkg::CACHE_LINES - 1; i >= 0; i--)
			if (zero_lines[i]) low_idx = i[lease_pkg::LINE_AW-1:0];
		for (int i = 0; i < lease_pkg::CACHE_LINES; i++)
			if (zero_lines[i]) high_idx = i[lease_pkg::LINE_AW-1:0];
	end

	// --------------------------------------------------
	// control sequence
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q         <= lease_pkg::ST_IDLE;
			done_o          <= 1'b0;
			swap_o          <= 1'b0;
			expired_o       <= 1'b0;
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;
			miss_followup_q <= 1'b0;
			miss_default_q  <= 1'b0;
			lfsr_q          <= lease_pkg::LFSR_SEED;
			for (int i = 0; i < lease_pkg::CACHE_LINES; i++)
				lease_q[i] <= '0;
		end else begin
			// result strobes are single cycle
			done_o          <= 1'b0;
			swap_o          <= 1'b0;
			expired_o       <= 1'b0;
			expired_multi_o <= 1'b0;
			default_o       <= 1'b0;
			case (state_q)
				lease_pkg::ST_IDLE: begin
					if (hit_i) begin
						if (miss_followup_q) begin
							miss_followup_q <= 1'b0;   // countdown already done on the miss
							lease_q[line_i] <= saved_lease_q;
						end else begin
							for (int i = 0; i < lease_pkg::CACHE_LINES; i++)
								if (!zero_lines[i]) lease_q[i] <= lease_q[i] - 1'b1;
							lease_q[line_i] <= sel_lease;   // renewal overrides the decrement
							default_o       <= ~tbl.llt_hit;
						end
					end else if (miss_i) begin
						for (int i = 0; i < lease_pkg::CACHE_LINES; i++)
							if (!zero_lines[i]) lease_q[i] <= lease_q[i] - 1'b1;
						if (sel_lease != '0) begin
							// line needs allocating so the victim is picked next cycle
							state_q         <= lease_pkg::ST_GEN_ADDR;
							miss_followup_q <= 1'b1;
							saved_lease_q   <= sel_lease;
							miss_default_q  <= ~tbl.llt_hit;
						end else begin
							done_o    <= 1'b1;   // zero lease is serviced without allocation
							default_o <= ~tbl.llt_hit;
						end
					end
				end
				lease_pkg::ST_GEN_ADDR: begin
					state_q   <= lease_pkg::ST_IDLE;
					done_o    <= 1'b1;
					swap_o    <= 1'b1;
					default_o <= miss_default_q;
					if (|zero_lines) begin
						addr_o          <= low_idx;
						expired_o       <= 1'b1;
						expired_multi_o <= (low_idx != high_idx);
					end else begin
						// nothing expired so the backup lfsr picks the victim
						addr_o <= lfsr_q[lease_pkg::LINE_AW-1:0];
						lfsr_q <= {lfsr_q[7:0], lfsr_q[8] ^ lfsr_q[4]};
					end
				end
				default: state_q <= lease_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

//--- lease_prob_select.sv
/* lease probability selector
   9 bit lfsr against the stored probability picks lease0 or lease1 */
`timescale 1ns/1ps

module lease_prob_select (
	input  logic                           clock_i,
	input  logic                           resetn_i,
	input  logic                           step_en_i,
	lease_table_if.sel                     tbl,
	output logic [lease_pkg::LEASE_W-1:0]  chosen_lease_o
);

	logic [8:0] lfsr_q;
	logic       feedback;

	// fibonacci, taps 9 and 5
	assign feedback = lfsr_q[8] ^ lfsr_q[4];

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			lfsr_q <= lease_pkg::LFSR_SEED;
		else if (step_en_i)
			lfsr_q <= {lfsr_q[7:0], feedback};   // one step per hit or miss
	end

	// low 8 bits span 0..255, so prob 256 is always lease0 and 0 never is
	always_comb begin
		if ({1'b0, lfsr_q[lease_pkg::PROB_W-2:0]} < tbl.prob)
			chosen_lease_o = tbl.lease0;
		else
			chosen_lease_o = tbl.lease1;
	end

endmodule

//--- lease_lookup_table.sv
/* lease lookup table
   entries keyed by reference address, searched in parallel each cycle */
`timescale 1ns/1ps

module lease_lookup_table (
	input  logic           clock_i,
	input  logic           resetn_i,
	lease_table_if.lookup  tbl
);

	logic [lease_pkg::REF_AW-1:0]  ref_q    [lease_pkg::LLT_ENTRIES];
	logic [lease_pkg::LEASE_W-1:0] lease0_q [lease_pkg::LLT_ENTRIES];
	logic [lease_pkg::LEASE_W-1:0] lease1_q [lease_pkg::LLT_ENTRIES];
	logic [lease_pkg::PROB_W-1:0]  prob_q   [lease_pkg::LLT_ENTRIES];
	logic [lease_pkg::LLT_ENTRIES-1:0] valid_q;

	// --------------------------------------------------
	// entry valid bits are set by a ref field write
	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			valid_q <= '0;
		else if (tbl.wr_en && tbl.wr_field == lease_pkg::FLD_REF)
			valid_q[tbl.wr_index] <= 1'b1;
	end

	// field storage
	always_ff @(posedge clock_i) begin
		if (tbl.wr_en) begin
			case (tbl.wr_field)
				lease_pkg::FLD_REF:    ref_q[tbl.wr_index]    <= tbl.wr_data;
				lease_pkg::FLD_LEASE0: lease0_q[tbl.wr_index] <= tbl.wr_data[lease_pkg::LEASE_W-1:0];
				lease_pkg::FLD_LEASE1: lease1_q[tbl.wr_index] <= tbl.wr_data[lease_pkg::LEASE_W-1:0];
				default:               prob_q[tbl.wr_index]   <= tbl.wr_data[lease_pkg::PROB_W-1:0];
			endcase
		end
	end

	// --------------------------------------------------
	// search scans top down so the lowest match lands last
	always_comb begin
		tbl.llt_hit = 1'b0;
		tbl.lease0  = '0;   // zero on no match
		tbl.lease1  = '0;
		tbl.prob    = '0;
		for (int i = lease_pkg::LLT_ENTRIES - 1; i >= 0; i--) begin
			if (valid_q[i] && ref_q[i] == tbl.search_addr) begin
				tbl.llt_hit = 1'b1;
				tbl.lease0  = lease0_q[i];
				tbl.lease1  = lease1_q[i];
				tbl.prob    = prob_q[i];
			end
		end
	end

endmodule

//--- lease_cfg_axil.sv
/* lease config slave
   axi4-lite writes to the lease table and default lease, default lease readback */
`timescale 1ns/1ps

module lease_cfg_axil (
	input  logic                            clock_i,
	input  logic                            resetn_i,
	input  logic [lease_pkg::AXI_AW-1:0]    s_awaddr_i,
	input  logic                            s_awvalid_i,
	output logic                            s_awready_o,
	input  logic [lease_pkg::AXI_DW-1:0]    s_wdata_i,
	input  logic                            s_wvalid_i,
	output logic                            s_wready_o,
	output logic [1:0]                      s_bresp_o,
	output logic                            s_bvalid_o,
	input  logic                            s_bready_i,
	input  logic [lease_pkg::AXI_AW-1:0]    s_araddr_i,
	input  logic                            s_arvalid_i,
	output logic                            s_arready_o,
	output logic [lease_pkg::AXI_DW-1:0]    s_rdata_o,
	output logic [1:0]                      s_rresp_o,
	output logic                            s_rvalid_o,
	input  logic                            s_rready_i,
	lease_table_if.cfg                      tbl,
	output logic [lease_pkg::LEASE_W-1:0]   default_lease_o
);

	logic wr_accept, rd_accept;
	logic bvalid_q, rvalid_q;
	logic [lease_pkg::AXI_DW-1:0] rdata_q;
	logic [lease_pkg::LEASE_W-1:0] default_lease_q;

	// --------------------------------------------------
	// write channel, aw and w taken together
	assign wr_accept   = s_awvalid_i & s_wvalid_i & ~bvalid_q;   // blocked while resp pending
	assign s_awready_o = wr_accept;
	assign s_wready_o  = wr_accept;
	assign s_bvalid_o  = bvalid_q;
	assign s_bresp_o   = lease_pkg::AXI_RESP_OKAY;

	// low half of the map goes to the table
	assign tbl.wr_en    = wr_accept & (s_awaddr_i < lease_pkg::CFG_DEFAULT_ADDR);
	assign tbl.wr_field = lease_pkg::llt_field_e'(s_awaddr_i[lease_pkg::LLT_FLD_LSB +: 2]);
	assign tbl.wr_index = s_awaddr_i[lease_pkg::LLT_IDX_LSB +: lease_pkg::LLT_AW];
	assign tbl.wr_data  = s_wdata_i[lease_pkg::REF_AW-1:0];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			bvalid_q        <= 1'b0;
			default_lease_q <= '0;
		end else begin
			if (wr_accept)
				bvalid_q <= 1'b1;
			else if (s_bready_i)
				bvalid_q <= 1'b0;   // drop once the master takes it
			if (wr_accept && s_awaddr_i == lease_pkg::CFG_DEFAULT_ADDR)
				default_lease_q <= s_wdata_i[lease_pkg::LEASE_W-1:0];
		end
	end

	assign default_lease_o = default_lease_q;

	// --------------------------------------------------
	// read channel, only the default lease reads back
	assign rd_accept   = s_arvalid_i & ~rvalid_q;
	assign s_arready_o = rd_accept;
	assign s_rvalid_o  = rvalid_q;
	assign s_rdata_o   = rdata_q;
	assign s_rresp_o   = lease_pkg::AXI_RESP_OKAY;

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			rvalid_q <= 1'b0;
		else if (rd_accept)
			rvalid_q <= 1'b1;
		else if (s_rready_i)
			rvalid_q <= 1'b0;
	end

	// read data, zero outside the default lease address
	always_ff @(posedge clock_i) begin
		if (rd_accept)
			rdata_q <= (s_araddr_i == lease_pkg::CFG_DEFAULT_ADDR) ?
				lease_pkg::AXI_DW'(default_lease_q) : '0;
	end

endmodule

//--- lease_table_if.sv
/* lease table interface
   table write port from the config side and the lookup results */
`timescale 1ns/1ps

interface lease_table_if;

	// write group
	logic                           wr_en;
	lease_pkg::llt_field_e          wr_field;
	logic [lease_pkg::LLT_AW-1:0]   wr_index;
	logic [lease_pkg::REF_AW-1:0]   wr_data;     // widest field is the ref address

	// lookup group
	logic [lease_pkg::REF_AW-1:0]   search_addr;
	logic                           llt_hit;
	logic [lease_pkg::LEASE_W-1:0]  lease0, lease1;
	logic [lease_pkg::PROB_W-1:0]   prob;

	modport cfg    (output wr_en, wr_field, wr_index, wr_data);
	modport lookup (input wr_en, wr_field, wr_index, wr_data, search_addr,
		output llt_hit, lease0, lease1, prob);
	modport sel    (input lease0, lease1, prob);
	modport ctrl   (output search_addr, input llt_hit);

endinterface

//--- lease_pkg.sv
/* lease cache package
   sizes, config address map and shared enums for the lease replacement controller */
package lease_pkg;

	// cache and table geometry
	localparam int CACHE_LINES = 8;
	localparam int LINE_AW     = 3;   // line index width
	localparam int LLT_ENTRIES = 8;
	localparam int LLT_AW      = 3;   // entry index width

	// field widths
	localparam int LEASE_W = 8;
	localparam int PROB_W  = 9;       // 256 -> always lease0, 0 -> always lease1
	localparam int REF_AW  = 16;      // reference word address

	// --------------------------------------------------
	// axi4-lite config side
	localparam int AXI_AW = 8;
	localparam int AXI_DW = 32;
	localparam logic [AXI_AW-1:0] CFG_DEFAULT_ADDR = 8'h80;
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
	localparam int LLT_FLD_LSB = 5;   // addr[6:5] selects the field
	localparam int LLT_IDX_LSB = 2;   // addr[4:2] selects the entry

	localparam logic [8:0] LFSR_SEED = 9'h155;

	// table field select, ref write also marks the entry valid
	typedef enum logic [1:0] {FLD_REF, FLD_LEASE0, FLD_LEASE1, FLD_PROB} llt_field_e;

	typedef enum logic [0:0] {ST_IDLE, ST_GEN_ADDR} ctrl_state_e;

endpackage
